/* hdl/rv_exec_config.svh */
`ifndef RV_EXEC_CONFIG_SVH
`define RV_EXEC_CONFIG_SVH

// Data path and register file geometry
`define XLEN   32
`define REG_AW 5

// RV32I major opcodes, instr[6:0]
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111

`endif

/* hdl/rv_exec_pkg.sv */
`default_nettype none

`include "rv_exec_config.svh"

package rv_exec_pkg;

    typedef logic [`XLEN-1:0]   word_t;     // One data word
    typedef logic [`REG_AW-1:0] reg_addr_t; // Register index
    typedef logic [31:0]        instr_t;    // Raw instruction word

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // Result is operand b, used by LUI
    } alu_op_e;

    typedef enum logic [1:0] {OPA_RS1, OPA_PC, OPA_ZERO} op_a_sel_e;
    typedef enum logic [1:0] {OPB_RS2, OPB_IMM, OPB_FOUR} op_b_sel_e;

    // Control transfer kind, none for straight-line code
    typedef enum logic [3:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JAL,
        BR_JALR
    } branch_kind_e;

    // Decoded instruction handed to execute
    typedef struct packed {
        word_t        pc;
        word_t        rs1_value;
        word_t        rs2_value;
        word_t        imm;
        alu_op_e      alu_op;
        op_a_sel_e    op_a_sel;
        op_b_sel_e    op_b_sel;
        branch_kind_e branch_kind;
        reg_addr_t    rd;
        logic         reg_write;
        logic         mem_read;
        logic         mem_write;
        logic         mem_to_reg;
    } id_ex_t;

    // Registered execute outcome for the memory stage
    typedef struct packed {
        word_t     alu_result;    // Also the memory address for loads and stores
        word_t     store_data;
        reg_addr_t rd;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        logic      mem_to_reg;
        logic      branch_taken;
        word_t     branch_target;
    } ex_mem_t;

endpackage

`default_nettype wire

/* hdl/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  rv_exec_pkg::alu_op_e alu_op,
    input  rv_exec_pkg::word_t   a,
    input  rv_exec_pkg::word_t   b,
    output rv_exec_pkg::word_t   result,
    output logic                 zero,
    output logic                 lt,
    output logic                 ltu
);
    import rv_exec_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];      // RV32I shifts use five bits only

    // Direct compares, immune to subtract overflow
    assign zero = (a == b);
    assign lt   = ($signed(a) < $signed(b));
    assign ltu  = (a < b);

    always_comb
    begin
        case (alu_op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = word_t'(lt);   // Zero-extended flag
            ALU_SLTU:   result = word_t'(ltu);
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = word_t'($signed(a) >>> shamt);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/branch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_unit (
    input  rv_exec_pkg::branch_kind_e branch_kind,
    input  rv_exec_pkg::word_t        pc,
    input  rv_exec_pkg::word_t        imm,
    input  rv_exec_pkg::word_t        rs1_value,
    input  rv_exec_pkg::word_t        rs2_value,
    output logic                      taken,
    output rv_exec_pkg::word_t        target
);
    import rv_exec_pkg::*;

    logic  eq, lt_s, lt_u;
    word_t jalr_sum;

    // Own comparators, the ALU is busy forming pc + 4 on jumps
    assign eq   = (rs1_value == rs2_value);
    assign lt_s = ($signed(rs1_value) < $signed(rs2_value));
    assign lt_u = (rs1_value < rs2_value);

    assign jalr_sum = rs1_value + imm;

    always_comb
    begin
        case (branch_kind)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt_s;
            BR_BGE:  taken = !lt_s;
            BR_BLTU: taken = lt_u;
            BR_BGEU: taken = !lt_u;
            BR_JAL,
            BR_JALR: taken = 1'b1;      // Unconditional
            default: taken = 1'b0;
        endcase
    end

    // JALR clears bit 0 of the computed address
    assign target = (branch_kind == BR_JALR) ? {jalr_sum[31:1], 1'b0} : pc + imm;

endmodule

`default_nettype wire

/* hdl/instr_decode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_config.svh"

module instr_decode (
    input  rv_exec_pkg::instr_t instr,
    input  rv_exec_pkg::word_t  pc,
    input  rv_exec_pkg::word_t  rs1_value,
    input  rv_exec_pkg::word_t  rs2_value,
    output rv_exec_pkg::id_ex_t dec
);
    import rv_exec_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // Sign-extended immediates, all formats built in parallel
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb
    begin
        // Bubble unless an opcode below claims it
        dec             = '0;
        dec.pc          = pc;
        dec.rs1_value   = rs1_value;
        dec.rs2_value   = rs2_value;
        dec.alu_op      = ALU_ADD;
        dec.op_a_sel    = OPA_ZERO;
        dec.op_b_sel    = OPB_IMM;
        dec.branch_kind = BR_NONE;

        case (opcode)
            `OPC_OP:
            begin
                dec.op_a_sel  = OPA_RS1;
                dec.op_b_sel  = OPB_RS2;
                dec.reg_write = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001:  dec.alu_op = ALU_SLL;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b011:  dec.alu_op = ALU_SLTU;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b101:  dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110:  dec.alu_op = ALU_OR;
                    default: dec.alu_op = ALU_AND;
                endcase
            end
            `OPC_OP_IMM:
            begin
                dec.op_a_sel  = OPA_RS1;
                dec.imm       = imm_i;      // Shamt sits in the low five bits
                dec.reg_write = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = ALU_ADD; // No subi in RV32I
                    3'b001:  dec.alu_op = ALU_SLL;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b011:  dec.alu_op = ALU_SLTU;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b101:  dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                    3'b110:  dec.alu_op = ALU_OR;
                    default: dec.alu_op = ALU_AND;
                endcase
            end
            `OPC_LOAD:
            begin
                dec.op_a_sel   = OPA_RS1;
                dec.imm        = imm_i;     // Address = rs1 + offset
                dec.reg_write  = 1'b1;
                dec.mem_read   = 1'b1;
                dec.mem_to_reg = 1'b1;
            end
            `OPC_STORE:
            begin
                dec.op_a_sel  = OPA_RS1;
                dec.imm       = imm_s;
                dec.mem_write = 1'b1;
            end
            `OPC_BRANCH:
            begin
                dec.op_a_sel = OPA_RS1;
                dec.op_b_sel = OPB_RS2;
                dec.alu_op   = ALU_SUB;
                dec.imm      = imm_b;
                case (funct3)
                    3'b000:  dec.branch_kind = BR_BEQ;
                    3'b001:  dec.branch_kind = BR_BNE;
                    3'b100:  dec.branch_kind = BR_BLT;
                    3'b101:  dec.branch_kind = BR_BGE;
                    3'b110:  dec.branch_kind = BR_BLTU;
                    3'b111:  dec.branch_kind = BR_BGEU;
                    default: dec.branch_kind = BR_NONE; // 010/011 reserved
                endcase
            end
            `OPC_LUI:
            begin
                dec.alu_op    = ALU_PASS_B;
                dec.imm       = imm_u;
                dec.reg_write = 1'b1;
            end
            `OPC_AUIPC:
            begin
                dec.op_a_sel  = OPA_PC;
                dec.imm       = imm_u;
                dec.reg_write = 1'b1;
            end
            `OPC_JAL, `OPC_JALR:
            begin
                // Link value pc + 4 comes out of the ALU
                dec.op_a_sel    = OPA_PC;
                dec.op_b_sel    = OPB_FOUR;
                dec.imm         = (opcode == `OPC_JAL) ? imm_j : imm_i;
                dec.branch_kind = (opcode == `OPC_JAL) ? BR_JAL : BR_JALR;
                dec.reg_write   = 1'b1;
            end
            default:
            begin
            end
        endcase

        // rd only meaningful when something gets written back
        if (dec.reg_write)
            dec.rd = instr[11:7];
    end

endmodule

`default_nettype wire

/* hdl/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  rv_exec_pkg::id_ex_t  dec,
    output logic                 out_valid,
    input  logic                 out_ready,
    output rv_exec_pkg::ex_mem_t out_bus
);
    import rv_exec_pkg::*;

    word_t   op_a;
    word_t   op_b;
    word_t   alu_result;
    logic    br_taken;
    word_t   br_target;
    logic    accept;
    ex_mem_t next_bus;

    // Free slot, or the held item leaves this same edge
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    // Operand A source
    always_comb
    begin
        case (dec.op_a_sel)
            OPA_RS1: op_a = dec.rs1_value;
            OPA_PC:  op_a = dec.pc;
            default: op_a = '0;     // LUI and bubbles
        endcase
    end

    // Operand B source
    always_comb
    begin
        case (dec.op_b_sel)
            OPB_RS2:  op_b = dec.rs2_value;
            OPB_FOUR: op_b = word_t'(4);    // Link address on jumps
            default:  op_b = dec.imm;
        endcase
    end

    alu u_alu (
        .alu_op (dec.alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result),
        .zero   (),
        .lt     (),
        .ltu    ()
    );

    branch_unit u_branch (
        .branch_kind (dec.branch_kind),
        .pc          (dec.pc),
        .imm         (dec.imm),
        .rs1_value   (dec.rs1_value),
        .rs2_value   (dec.rs2_value),
        .taken       (br_taken),
        .target      (br_target)
    );

    // Outcome assembled from the same cycle's inputs, no stale control
    always_comb
    begin
        next_bus               = '0;
        next_bus.alu_result    = alu_result;
        next_bus.store_data    = dec.rs2_value;
        next_bus.rd            = dec.rd;
        next_bus.reg_write     = dec.reg_write;
        next_bus.mem_read      = dec.mem_read;
        next_bus.mem_write     = dec.mem_write;
        next_bus.mem_to_reg    = dec.mem_to_reg;
        next_bus.branch_taken  = br_taken;
        next_bus.branch_target = br_target;
    end

    // Single output slot
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            out_valid <= 1'b0;
            out_bus   <= '0;
        end
        else if (accept)
        begin
            out_valid <= 1'b1;
            out_bus   <= next_bus;
        end
        else if (out_ready)
        begin
            out_valid <= 1'b0;      // Drained, payload left as is
        end
    end

endmodule

`default_nettype wire

/* hdl/exec_top.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    output logic                 in_ready,
    input  rv_exec_pkg::instr_t  instr,
    input  rv_exec_pkg::word_t   pc,
    input  rv_exec_pkg::word_t   rs1_value,
    input  rv_exec_pkg::word_t   rs2_value,
    output logic                 out_valid,
    input  logic                 out_ready,
    output rv_exec_pkg::ex_mem_t out_bus
);
    import rv_exec_pkg::*;

    id_ex_t dec;    // Decoded instruction, same cycle

    instr_decode u_decode (
        .instr     (instr),
        .pc        (pc),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .dec       (dec)
    );

    // Handshake passes straight to the stage register
    execute_stage u_exec (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .dec       (dec),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_bus   (out_bus)
    );

endmodule

`default_nettype wire

/* testbench/exec_props.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_props (
    input logic                 clk,
    input logic                 rst,
    input logic                 in_valid,
    input logic                 in_ready,
    input logic                 out_valid,
    input logic                 out_ready,
    input rv_exec_pkg::ex_mem_t out_bus
);
    int fails = 0;      // Failure count, summed into the final verdict

    // Nothing leaves the stage while reset is held
    reset_quiet: assert property (@(posedge clk) rst |-> out_valid !== 1'b1)
    else
    begin
        fails++;
        $error("out_valid high while rst is asserted");
    end

    // A stalled output keeps its payload and its valid
    hold_when_stalled: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_bus))
    else
    begin
        fails++;
        $error("out_bus or out_valid changed while the consumer stalled");
    end

    // An accepted instruction occupies the slot on the next edge
    accept_fills: assert property (@(posedge clk) disable iff (rst)
        in_valid && in_ready |=> out_valid)
    else
    begin
        fails++;
        $error("accepted instruction did not show up on the output");
    end

endmodule

bind exec_top exec_props u_props (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_bus   (out_bus)
);

`default_nettype wire

/* testbench/exec_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "rv_exec_config.svh"

module exec_tb;
    import rv_exec_pkg::*;

    logic     clk, rst, in_valid, in_ready, out_valid, out_ready;
    instr_t   instr;
    word_t    pc, rs1_value, rs2_value;
    ex_mem_t  out_bus;
    ex_mem_t  exp_q[$];     // Expected outputs, accept order
    bit [1:0] care_q[$];    // Bit 0 result checked, bit 1 target checked
    int       errors = 0;
    int       checks = 0;
    int       err_mark = 0;
    int       passed = 0;
    int       failed = 0;
    bit       stall_on;

    // Equal, signed-less, unsigned-less, overflow-prone both ways
    word_t pair_a [5] = '{32'h1234_5678, 32'hffff_fffb, 32'h0000_0003, 32'h7fff_ffff, 32'h8000_0000};
    word_t pair_b [5] = '{32'h1234_5678, 32'h0000_0003, 32'hffff_fff0, 32'h8000_0000, 32'h7fff_ffff};

    exec_top u_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Random back-pressure only in the burst test
    always @(negedge clk)
        out_ready = stall_on ? ($urandom % 4 != 0) : 1'b1;

    function automatic instr_t branch_word(logic [12:0] imm, logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic instr_t jal_word(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
    endfunction

    // Reference behavior per RV32I, care marks fields that carry meaning
    function automatic ex_mem_t model(instr_t i, word_t p, word_t a, word_t b,
                                      output bit [1:0] care);
        ex_mem_t    e;
        word_t      y;
        logic [2:0] f3;
        e            = '0;
        f3           = i[14:12];
        y            = (i[6:0] == `OPC_OP) ? b : {{20{i[31]}}, i[31:20]};  // rs2 or I-imm
        e.store_data = b;
        care         = 2'b01;
        case (i[6:0])
            `OPC_OP, `OPC_OP_IMM:
                case (f3)
                    3'd0: e.alu_result = (i[30] && i[6:0] == `OPC_OP) ? a - y : a + y;
                    3'd1: e.alu_result = a << y[4:0];
                    3'd2: e.alu_result = {31'b0, $signed(a) < $signed(y)};
                    3'd3: e.alu_result = {31'b0, a < y};
                    3'd4: e.alu_result = a ^ y;
                    3'd5: e.alu_result = i[30] ? word_t'($signed(a) >>> y[4:0]) : a >> y[4:0];
                    3'd6: e.alu_result = a | y;
                    3'd7: e.alu_result = a & y;
                endcase
            `OPC_LOAD:  e.alu_result = a + y;                     // Load address
            `OPC_STORE: e.alu_result = a + {{20{i[31]}}, i[31:25], i[11:7]};
            `OPC_LUI:   e.alu_result = {i[31:12], 12'h0};
            `OPC_AUIPC: e.alu_result = p + {i[31:12], 12'h0};
            `OPC_BRANCH:
            begin
                care            = 2'b10;
                e.branch_target = p + {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
                case (f3)
                    3'd0:    e.branch_taken = (a == b);
                    3'd1:    e.branch_taken = (a != b);
                    3'd4:    e.branch_taken = ($signed(a) < $signed(b));
                    3'd5:    e.branch_taken = ($signed(a) >= $signed(b));
                    3'd6:    e.branch_taken = (a < b);
                    default: e.branch_taken = (a >= b);
                endcase
            end
            `OPC_JAL, `OPC_JALR:
            begin
                care            = 2'b11;
                e.alu_result    = p + 4;    // Link address
                e.branch_taken  = 1'b1;
                e.branch_target = (i[6:0] == `OPC_JAL) ?
                    p + {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0} : (a + y) & ~32'd1;
            end
            default:
                care = 2'b00;   // Bubble, only flags matter
        endcase
        e.mem_read   = (i[6:0] == `OPC_LOAD);
        e.mem_to_reg = e.mem_read;
        e.mem_write  = (i[6:0] == `OPC_STORE);
        e.reg_write  = care[0] && (i[6:0] != `OPC_STORE);
        e.rd         = e.reg_write ? i[11:7] : '0;
        return e;
    endfunction

    task automatic check(string name, word_t exp, word_t got);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    // Present one instruction, hold it until taken
    task automatic send(instr_t i, word_t p, word_t a, word_t b);
        ex_mem_t  e;
        bit [1:0] c;
        int       t;
        e = model(i, p, a, b, c);
        @(negedge clk);
        instr     = i;
        pc        = p;
        rs1_value = a;
        rs2_value = b;
        in_valid  = 1'b1;
        t         = 0;
        do
        begin
            @(posedge clk);
            t++;
        end
        while (!in_ready && t < 50);
        if (in_ready)
        begin
            exp_q.push_back(e);
            care_q.push_back(c);
        end
        else
        begin
            errors++;
            $display("Timeout at %0t, instruction %h was never accepted", $time, i);
        end
    endtask

    // Drain, then one report line for the test
    task automatic finish_test(string name);
        int t;
        @(negedge clk);
        in_valid = 1'b0;
        stall_on = 1'b0;
        t        = 0;
        while (exp_q.size() > 0 && t < 50)
        begin
            @(negedge clk);
            t++;
        end
        assert (exp_q.size() == 0)
        else
        begin
            errors++;
            $display("Timeout in %s, %0d results never came out", name, exp_q.size());
            exp_q.delete();
            care_q.delete();
        end
        if (errors == err_mark)
            passed++;
        else
            failed++;
        $display("Test %-10s %s, %0d errors", name, (errors == err_mark) ? "passed" : "failed",
                 errors - err_mark);
        err_mark = errors;
    endtask

    // Consumer side, each handshake against the oldest expected item
    always @(posedge clk)
    begin : compare_out
        ex_mem_t  e;
        bit [1:0] c;
        if (!rst && out_valid && out_ready)
        begin
            assert (exp_q.size() > 0)
            else
            begin
                errors++;
                $display("Output at %0t with no instruction waiting for it", $time);
            end
            if (exp_q.size() > 0)
            begin
                e = exp_q.pop_front();
                c = care_q.pop_front();
                if (c[0])
                    check("alu_result", e.alu_result, out_bus.alu_result);
                if (c[1])
                    check("branch_target", e.branch_target, out_bus.branch_target);
                check("store_data", e.store_data, out_bus.store_data);
                check("rd", e.rd, out_bus.rd);
                check("reg_write", e.reg_write, out_bus.reg_write);
                check("mem_read", e.mem_read, out_bus.mem_read);
                check("mem_write", e.mem_write, out_bus.mem_write);
                check("mem_to_reg", e.mem_to_reg, out_bus.mem_to_reg);
                check("branch_taken", e.branch_taken, out_bus.branch_taken);
            end
        end
    end

    initial
    begin
        word_t      a, b, p;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm;
        void'($urandom(32'ha541));
        rst       = 1'b1;
        in_valid  = 1'b0;
        instr     = '0;
        pc        = '0;
        rs1_value = '0;
        rs2_value = '0;
        out_ready = 1'b1;
        stall_on  = 1'b0;

        repeat (10)
        begin
            @(negedge clk);
            check("out_valid", 0, out_valid);
            check("in_ready", 1, in_ready);
        end
        rst = 1'b0;
        @(negedge clk);
        check("out_valid", 0, out_valid);
        check("in_ready", 1, in_ready);
        finish_test("reset");

        for (int n = 0; n < 32; n++)
        begin
            f3  = n[2:0];
            a   = $urandom;
            b   = $urandom;
            p   = $urandom & ~32'h3;
            f7  = (n[3] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;  // sub, sra, srai
            imm = (f3 == 3'd1 || f3 == 3'd5) ? {f7, b[4:0]} : b[11:0];
            send({f7, 10'h0, f3, 5'd9, `OPC_OP}, p, a, b);
            send({imm, 5'd1, f3, 5'd10, `OPC_OP_IMM}, p, a, b);
        end
        finish_test("arith");

        for (int n = 0; n < 8; n++)
        begin
            a = $urandom;
            b = $urandom;
            p = $urandom & ~32'h3;
            send({b[31:12], 5'd3, `OPC_LUI}, p, a, b);
            send({b[31:12], 5'd4, `OPC_AUIPC}, p, a, b);
            send(jal_word(b[20:0], 5'd1), p, a, b);
            send({b[11:0], 5'd2, 3'b000, 5'd1, `OPC_JALR}, p, a, b);    // Odd sums common
        end
        finish_test("upper_jump");

        for (int k = 0; k < 8; k++)
        begin
            if (k != 2 && k != 3)   // 010 and 011 are reserved
            begin
                for (int j = 0; j < 5; j++)
                begin
                    b = $urandom;
                    p = $urandom & ~32'h3;
                    send(branch_word(b[12:0], k[2:0]), p, pair_a[j], pair_b[j]);
                    send(branch_word(b[12:0], k[2:0]), p, pair_b[j], pair_a[j]);
                end
            end
        end
        finish_test("branch");

        for (int n = 0; n < 8; n++)
        begin
            a = $urandom;
            b = $urandom;
            send({b[31:20], 5'd1, 3'b010, 5'd11, `OPC_LOAD}, p, a, b);
            send({b[31:25], 5'd2, 5'd1, 3'b010, b[11:7], `OPC_STORE}, p, a, b);
            send({b[31:7], 7'b1110011}, p, a, b);   // System, not supported
            send({b[31:7], 7'b0001111}, p, a, b);   // Fence, not supported
        end
        finish_test("mem_bubble");

        stall_on = 1'b1;
        for (int n = 0; n < 60; n++)
        begin
            f3 = 3'($urandom);
            send({7'h00, 10'h0, f3, 5'd12, `OPC_OP}, $urandom & ~32'h3, $urandom, $urandom);
        end
        finish_test("burst");

        $display("Tests passed %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 passed, failed, checks, errors, u_dut.u_props.fails);
        if (errors == 0 && u_dut.u_props.fails == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+hdl
hdl/rv_exec_pkg.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/instr_decode.sv
hdl/execute_stage.sv
hdl/exec_top.sv
testbench/exec_props.sv
testbench/exec_tb.sv
